// ==== include/ex_stage_vectors.svh ====
// columns: name, aluop, alusel, reg1, reg2, wd, wreg, expected wdata, wreg, ov
// HI/LO entries build on the ones before them, order matters

localparam logic [ex_pkg::ALUSEL_W-1:0] c_nop = ex_pkg::EXE_RES_NOP;
localparam logic [ex_pkg::ALUSEL_W-1:0] c_log = ex_pkg::EXE_RES_LOGIC;
localparam logic [ex_pkg::ALUSEL_W-1:0] c_shf = ex_pkg::EXE_RES_SHIFT;
localparam logic [ex_pkg::ALUSEL_W-1:0] c_ari = ex_pkg::EXE_RES_ARITHMETIC;
localparam logic [ex_pkg::ALUSEL_W-1:0] c_mul = ex_pkg::EXE_RES_MUL;
localparam logic [ex_pkg::ALUSEL_W-1:0] c_mov = ex_pkg::EXE_RES_MOVE;

task automatic load_vectors();
    add_vec("or", ex_pkg::EXE_OR_OP, c_log, 'hf0f00000, 'hf0f, 1, 1, 'hf0f00f0f, 1, 0);
    add_vec("and", ex_pkg::EXE_AND_OP, c_log, 'hff00ff00, 'h0ff00ff0, 2, 1, 'h0f000f00, 1, 0);
    add_vec("nor", ex_pkg::EXE_NOR_OP, c_log, 'h0f0f0000, 'hff, 3, 1, 'hf0f0ff00, 1, 0);
    add_vec("xor", ex_pkg::EXE_XOR_OP, c_log, 'haaaa5555, 'hffff0000, 4, 1, 'h55555555, 1, 0);
    add_vec("sll", ex_pkg::EXE_SLL_OP, c_shf, 'h4, 'h8000000f, 5, 1, 'hf0, 1, 0);
    add_vec("sra", ex_pkg::EXE_SRA_OP, c_shf, 'h8, 'h80000000, 6, 1, 'hff800000, 1, 0);
    add_vec("srl", ex_pkg::EXE_SRL_OP, c_shf, 'h8, 'h80000000, 27, 1, 'h00800000, 1, 0);
    add_vec("sub", ex_pkg::EXE_SUB_OP, c_ari, 'h3, 'h5, 7, 1, 'hfffffffe, 1, 0);
    add_vec("slt", ex_pkg::EXE_SLT_OP, c_ari, 'hfffffffe, 'h1, 8, 1, 'h1, 1, 0);
    add_vec("sltu", ex_pkg::EXE_SLTU_OP, c_ari, 'hfffffffe, 'h1, 9, 1, 'h0, 1, 0);
    add_vec("clz", ex_pkg::EXE_CLZ_OP, c_ari, 'h00010000, 'h0, 10, 1, 'd15, 1, 0);
    add_vec("clo", ex_pkg::EXE_CLO_OP, c_ari, 'hfff00000, 'h0, 11, 1, 'd12, 1, 0);
    add_vec("add", ex_pkg::EXE_ADD_OP, c_ari, 'h7ffffffe, 'h1, 28, 1, 'h7fffffff, 1, 0);
    add_vec("addi", ex_pkg::EXE_ADDI_OP, c_ari, 'hfffffff0, 'h20, 29, 1, 'h10, 1, 0);
    add_vec("subu", ex_pkg::EXE_SUBU_OP, c_ari, 'h80000000, 'h1, 0, 0, 'h7fffffff, 0, 0);
    add_vec("add_ov", ex_pkg::EXE_ADD_OP, c_ari, 'h7fffffff, 'h1, 12, 1, 'h80000000, 0, 1);
    add_vec("sub_ov", ex_pkg::EXE_SUB_OP, c_ari, 'h80000000, 'h1, 13, 1, 'h7fffffff, 0, 1);
    add_vec("addi_ov", ex_pkg::EXE_ADDI_OP, c_ari, 'h80000000, 'h80000000, 30, 1, 'h0, 0, 1);
    add_vec("addu_wrap", ex_pkg::EXE_ADDU_OP, c_ari, 'h7fffffff, 'h1, 14, 1, 'h80000000, 1, 0);
    add_vec("addiu_wrap", ex_pkg::EXE_ADDIU_OP, c_ari, 'h7fffffff, 'h1, 31, 1, 'h80000000, 1, 0);
    add_vec("mult", ex_pkg::EXE_MULT_OP, c_nop, 'hfffffffe, 'h3, 0, 0, 'h0, 0, 0);
    add_vec("mfhi_mult", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 15, 1, 'hffffffff, 1, 0);
    add_vec("mflo_mult", ex_pkg::EXE_MFLO_OP, c_mov, 'h0, 'h0, 16, 1, 'hfffffffa, 1, 0);
    add_vec("multu", ex_pkg::EXE_MULTU_OP, c_nop, 'hffffffff, 'h2, 0, 0, 'h0, 0, 0);
    add_vec("mul", ex_pkg::EXE_MUL_OP, c_mul, 'h00010001, 'h00010001, 17, 1, 'h00020001, 1, 0);
    add_vec("mfhi_mul", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 18, 1, 'h1, 1, 0);
    add_vec("mthi", ex_pkg::EXE_MTHI_OP, c_nop, 'h12345678, 'h0, 0, 0, 'h0, 0, 0);
    add_vec("mflo_mthi", ex_pkg::EXE_MFLO_OP, c_mov, 'h0, 'h0, 19, 1, 'hfffffffe, 1, 0);
    add_vec("mfhi_mthi", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 20, 1, 'h12345678, 1, 0);
    add_vec("mtlo", ex_pkg::EXE_MTLO_OP, c_nop, 'h10, 'h0, 0, 0, 'h0, 0, 0);
    add_vec("madd", ex_pkg::EXE_MADD_OP, c_nop, 'hffffffff, 'h20, 0, 0, 'h0, 0, 0);
    add_vec("mfhi_madd", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 21, 1, 'h12345677, 1, 0);
    add_vec("maddu", ex_pkg::EXE_MADDU_OP, c_nop, 'hffffffff, 'h20, 0, 0, 'h0, 0, 0);
    add_vec("mfhi_maddu", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 22, 1, 'h12345697, 1, 0);
    add_vec("mflo_maddu", ex_pkg::EXE_MFLO_OP, c_mov, 'h0, 'h0, 23, 1, 'hffffffd0, 1, 0);
    add_vec("msub", ex_pkg::EXE_MSUB_OP, c_nop, 'h2, 'h3, 0, 0, 'h0, 0, 0);
    add_vec("mflo_msub", ex_pkg::EXE_MFLO_OP, c_mov, 'h0, 'h0, 24, 1, 'hffffffca, 1, 0);
    add_vec("msubu", ex_pkg::EXE_MSUBU_OP, c_nop, 'h80000000, 'h4, 0, 0, 'h0, 0, 0);
    add_vec("mfhi_msubu", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 25, 1, 'h12345695, 1, 0);
    add_vec("mthi_zero", ex_pkg::EXE_MTHI_OP, c_nop, 'h0, 'h0, 0, 0, 'h0, 0, 0);
    // borrows through bit 63, HI/LO wraps around
    add_vec("msubu_wrap", ex_pkg::EXE_MSUBU_OP, c_nop, 'h00010000, 'h00010000, 0, 0, 'h0, 0, 0);
    add_vec("mfhi_wrap", ex_pkg::EXE_MFHI_OP, c_mov, 'h0, 'h0, 26, 1, 'hffffffff, 1, 0);
endtask

// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/100ps

module ex_stage_tb;

    typedef struct {
        string                         name;
        logic [ex_pkg::ALUOP_W-1:0]    aluop;
        logic [ex_pkg::ALUSEL_W-1:0]   alusel;
        logic [ex_pkg::WORD_W-1:0]     reg1;
        logic [ex_pkg::WORD_W-1:0]     reg2;
        logic [ex_pkg::REG_ADDR_W-1:0] wd;
        logic                          wreg;
        logic [ex_pkg::WORD_W-1:0]     exp_wdata;
        logic                          exp_wreg;
        logic                          exp_ov;
    } vec_t;

    logic                          clk;
    logic                          reset_i;
    logic                          valid_i;
    logic [ex_pkg::ALUOP_W-1:0]    aluop_i;
    logic [ex_pkg::ALUSEL_W-1:0]   alusel_i;
    logic [ex_pkg::WORD_W-1:0]     reg1_i;
    logic [ex_pkg::WORD_W-1:0]     reg2_i;
    logic [ex_pkg::REG_ADDR_W-1:0] wd_i;
    logic                          wreg_i;
    logic                          valid_o;
    logic [ex_pkg::REG_ADDR_W-1:0] wd_o;
    logic                          wreg_o;
    logic [ex_pkg::WORD_W-1:0]     wdata_o;
    logic                          ov_o;
    logic                          stall_o;
    vec_t                          vecs[$];  // filled by load_vectors

    ex_stage ex_stage_i (.*);

    task automatic add_vec(
        input string                         name,
        input logic [ex_pkg::ALUOP_W-1:0]    aluop,
        input logic [ex_pkg::ALUSEL_W-1:0]   alusel,
        input logic [ex_pkg::WORD_W-1:0]     reg1,
        input logic [ex_pkg::WORD_W-1:0]     reg2,
        input logic [ex_pkg::REG_ADDR_W-1:0] wd,
        input logic                          wreg,
        input logic [ex_pkg::WORD_W-1:0]     exp_wdata,
        input logic                          exp_wreg,
        input logic                          exp_ov
    );
        vec_t v;
        v = '{name, aluop, alusel, reg1, reg2, wd, wreg, exp_wdata, exp_wreg, exp_ov};
        vecs.push_back(v);
    endtask

    `include "ex_stage_vectors.svh"

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(
        input string                     test,
        input logic [ex_pkg::WORD_W-1:0] exp,
        input logic [ex_pkg::WORD_W-1:0] act
    );
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_addr(
        input string                         test,
        input logic [ex_pkg::REG_ADDR_W-1:0] exp,
        input logic [ex_pkg::REG_ADDR_W-1:0] act
    );
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic check_bit(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    // nothing in flight, every flag low
    task automatic check_idle(input string when);
        check_bit({when, " valid_o"}, 1'b0, valid_o);
        check_bit({when, " wreg_o"}, 1'b0, wreg_o);
        check_bit({when, " ov_o"}, 1'b0, ov_o);
        check_bit({when, " stall_o"}, 1'b0, stall_o);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that shows the result
    task automatic run_vector(input vec_t v);
        logic acc;
        acc      = v.aluop inside {ex_pkg::EXE_MADD_OP, ex_pkg::EXE_MADDU_OP,
                                   ex_pkg::EXE_MSUB_OP, ex_pkg::EXE_MSUBU_OP};
        valid_i  = 1'b1;
        aluop_i  = v.aluop;
        alusel_i = v.alusel;
        reg1_i   = v.reg1;
        reg2_i   = v.reg2;
        wd_i     = v.wd;
        wreg_i   = v.wreg;
        #1;  // stall_o follows the new inputs
        check_bit({v.name, " stall_o"}, acc, stall_o);
        if (acc) begin
            @(posedge clk);  // inputs held across the stall
            #1;
            check_bit({v.name, " valid_o after stall"}, 1'b0, valid_o);
            check_bit({v.name, " stall_o second cycle"}, 1'b0, stall_o);
        end
        @(posedge clk);
        #1;
        check_bit({v.name, " valid_o"}, 1'b1, valid_o);
        check_addr({v.name, " wd_o"}, v.wd, wd_o);
        check_word({v.name, " wdata_o"}, v.exp_wdata, wdata_o);
        check_bit({v.name, " wreg_o"}, v.exp_wreg, wreg_o);
        check_bit({v.name, " ov_o"}, v.exp_ov, ov_o);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset_i  = 1'b1;
        valid_i  = 1'b0;
        aluop_i  = ex_pkg::EXE_NOP_OP;
        alusel_i = ex_pkg::EXE_RES_NOP;
        reg1_i   = '0;
        reg2_i   = '0;
        wd_i     = '0;
        wreg_i   = 1'b0;
        load_vectors();
        repeat (16) begin
            @(posedge clk);
            #1;
            check_idle("reset");
        end
        reset_i = 1'b0;
        @(posedge clk);
        #1;
        check_idle("after reset");
        foreach (vecs[i]) begin
            run_vector(vecs[i]);  // back to back unless a stall intervenes
        end
        valid_i = 1'b0;
        @(posedge clk);
        #1;
        check_idle("drain");
        $display("Result: PASSED");
        $finish;
    end

    // three cycles per vector covers stalls, plus reset and drain
    initial begin
        #1;
        repeat (vecs.size() * 3 + 40) @(posedge clk);
        stop_with_error("Timeout: the vector loop did not finish in time");
    end

endmodule

// ==== ex_stage.f ====
+incdir+include
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mul_hilo.sv
rtl/ex_result_sel.sv
rtl/ex_stage.sv
dv/ex_stage_tb.sv

// ==== rtl/ex_alu.sv ====
`timescale 1ns/100ps

module ex_alu (
    input  logic [ex_pkg::ALUOP_W-1:0] aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]  reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]  reg2_i,
    output logic [ex_pkg::WORD_W-1:0]  alu_result_o,
    output logic                       alu_ov_o
);

    logic                      sub_sel;
    logic                      ov_op;
    logic [ex_pkg::WORD_W-1:0] reg2_mux;
    logic [ex_pkg::WORD_W-1:0] sum;
    logic                      add_sign;
    logic                      ov_raw;
    logic                      lt_signed;
    logic                      lt_unsigned;
    logic [ex_pkg::WORD_W:0]   wide_sum;

    // number of zero bits above the first set bit, 0..WORD_W
    function automatic logic [ex_pkg::WORD_W-1:0] lead_zeros(
        input logic [ex_pkg::WORD_W-1:0] w
    );
        logic [ex_pkg::WORD_W-1:0] n;
        logic                      hit;
        n   = '0;
        hit = 1'b0;
        for (int i = ex_pkg::WORD_W - 1; i >= 0; i--) begin
            hit = hit | w[i];
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // slt shares the subtractor
    assign sub_sel = (aluop_i == ex_pkg::EXE_SUB_OP) ||
                     (aluop_i == ex_pkg::EXE_SUBU_OP) ||
                     (aluop_i == ex_pkg::EXE_SLT_OP);
    assign ov_op   = (aluop_i == ex_pkg::EXE_ADD_OP) ||
                     (aluop_i == ex_pkg::EXE_ADDI_OP) ||
                     (aluop_i == ex_pkg::EXE_SUB_OP);

    assign reg2_mux = sub_sel ? (~reg2_i + 1'b1) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // sign of the operand actually added, so that -(-2^31) still counts as positive
    assign add_sign = sub_sel ? ~reg2_i[ex_pkg::WORD_W-1] : reg2_i[ex_pkg::WORD_W-1];
    assign ov_raw   = (reg1_i[ex_pkg::WORD_W-1] == add_sign) &&
                      (sum[ex_pkg::WORD_W-1] != reg1_i[ex_pkg::WORD_W-1]);

    assign lt_signed   = sum[ex_pkg::WORD_W-1] ^ ov_raw;  // true sign of reg1 - reg2
    assign lt_unsigned = reg1_i < reg2_i;

    assign alu_ov_o = ov_op && ov_raw;

    // one spare sign bit, the true result overflows when the top two bits differ
    assign wide_sum = sub_sel ?
        {reg1_i[ex_pkg::WORD_W-1], reg1_i} - {reg2_i[ex_pkg::WORD_W-1], reg2_i} :
        {reg1_i[ex_pkg::WORD_W-1], reg1_i} + {reg2_i[ex_pkg::WORD_W-1], reg2_i};

    always_comb begin
        case (aluop_i)
            ex_pkg::EXE_OR_OP:    alu_result_o = reg1_i | reg2_i;
            ex_pkg::EXE_AND_OP:   alu_result_o = reg1_i & reg2_i;
            ex_pkg::EXE_NOR_OP:   alu_result_o = ~(reg1_i | reg2_i);
            ex_pkg::EXE_XOR_OP:   alu_result_o = reg1_i ^ reg2_i;
            ex_pkg::EXE_SLL_OP:   alu_result_o = reg2_i << reg1_i[4:0];
            ex_pkg::EXE_SRL_OP:   alu_result_o = reg2_i >> reg1_i[4:0];
            ex_pkg::EXE_SRA_OP:   alu_result_o = $signed(reg2_i) >>> reg1_i[4:0];
            ex_pkg::EXE_ADD_OP,
            ex_pkg::EXE_ADDU_OP,
            ex_pkg::EXE_ADDI_OP,
            ex_pkg::EXE_ADDIU_OP,
            ex_pkg::EXE_SUB_OP,
            ex_pkg::EXE_SUBU_OP:  alu_result_o = sum;
            ex_pkg::EXE_SLT_OP:   alu_result_o = {{(ex_pkg::WORD_W-1){1'b0}}, lt_signed};
            ex_pkg::EXE_SLTU_OP:  alu_result_o = {{(ex_pkg::WORD_W-1){1'b0}}, lt_unsigned};
            ex_pkg::EXE_CLZ_OP:   alu_result_o = lead_zeros(reg1_i);
            ex_pkg::EXE_CLO_OP:   alu_result_o = lead_zeros(~reg1_i);  // leading ones
            default:              alu_result_o = '0;
        endcase
    end

    // overflow is only meaningful for the trapping adds
    always_comb begin
        assert (alu_ov_o == ((aluop_i inside {ex_pkg::EXE_ADD_OP, ex_pkg::EXE_ADDI_OP,
                                              ex_pkg::EXE_SUB_OP}) &&
                             (wide_sum[ex_pkg::WORD_W] != wide_sum[ex_pkg::WORD_W-1])))
            else $error("overflow flag wrong for opcode %h", aluop_i);
    end

endmodule

// ==== rtl/ex_mul_hilo.sv ====
`timescale 1ns/100ps

module ex_mul_hilo (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  logic [ex_pkg::ALUOP_W-1:0] aluop_i,
    input  logic [ex_pkg::WORD_W-1:0]  reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]  reg2_i,
    output logic [ex_pkg::WORD_W-1:0]  mul_result_o,
    output logic [ex_pkg::WORD_W-1:0]  move_result_o,
    output logic                       stall_o
);

    logic                        signed_op;
    logic                        acc_op;
    logic                        neg_op;
    logic                        accept;
    logic [2*ex_pkg::WORD_W-1:0] op1_ext;
    logic [2*ex_pkg::WORD_W-1:0] op2_ext;
    ex_pkg::hilo_t               product;
    ex_pkg::hilo_t               hilo;      // architectural HI/LO
    ex_pkg::hilo_t               prod_tmp;  // product held between accumulate steps
    logic                        step;      // first accumulate step done

    assign signed_op = (aluop_i == ex_pkg::EXE_MUL_OP) ||
                       (aluop_i == ex_pkg::EXE_MULT_OP) ||
                       (aluop_i == ex_pkg::EXE_MADD_OP) ||
                       (aluop_i == ex_pkg::EXE_MSUB_OP);
    assign neg_op    = (aluop_i == ex_pkg::EXE_MSUB_OP) ||
                       (aluop_i == ex_pkg::EXE_MSUBU_OP);
    assign acc_op    = neg_op ||
                       (aluop_i == ex_pkg::EXE_MADD_OP) ||
                       (aluop_i == ex_pkg::EXE_MADDU_OP);

    // extend to 64 bits first, then the low half of one product covers signed and unsigned
    assign op1_ext = {{ex_pkg::WORD_W{signed_op & reg1_i[ex_pkg::WORD_W-1]}}, reg1_i};
    assign op2_ext = {{ex_pkg::WORD_W{signed_op & reg2_i[ex_pkg::WORD_W-1]}}, reg2_i};
    assign product.dword = op1_ext * op2_ext;

    // accumulate ops hold the pipe for their first cycle
    assign stall_o = valid_i && acc_op && !step;
    assign accept  = valid_i && !stall_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo.dword <= '0;
            step       <= 1'b0;
        end else begin
            if (stall_o) begin
                step <= 1'b1;
            end else if (accept) begin
                step <= 1'b0;
            end

            if (accept) begin
                case (aluop_i)
                    ex_pkg::EXE_MULT_OP,
                    ex_pkg::EXE_MULTU_OP: hilo <= product;
                    ex_pkg::EXE_MTHI_OP:  hilo.w.hi <= reg1_i;
                    ex_pkg::EXE_MTLO_OP:  hilo.w.lo <= reg1_i;
                    ex_pkg::EXE_MADD_OP,
                    ex_pkg::EXE_MADDU_OP,
                    ex_pkg::EXE_MSUB_OP,
                    ex_pkg::EXE_MSUBU_OP: hilo.dword <= hilo.dword + prod_tmp.dword;
                    default: ;
                endcase
            end
        end
    end

    // msub adds the negated product, wraps mod 2^64
    always_ff @(posedge clk) begin
        if (stall_o) begin
            prod_tmp.dword <= neg_op ? -product.dword : product.dword;
        end
    end

    assign mul_result_o = product.w.lo;  // mul keeps only the low word

    always_comb begin
        case (aluop_i)
            ex_pkg::EXE_MFHI_OP: move_result_o = hilo.w.hi;
            ex_pkg::EXE_MFLO_OP: move_result_o = hilo.w.lo;
            default:             move_result_o = '0;
        endcase
    end

    // one stall cycle per accumulate, the held op completes next cycle on the same operands
    assert property (@(posedge clk) disable iff (reset_i)
        (valid_i && stall_o) |=> (!stall_o && $stable(aluop_i) &&
                                  $stable(reg1_i) && $stable(reg2_i)))
        else $error("accumulate op not held or stalled for more than one cycle");

    // step is only pending while the source holds an accumulate op
    assert property (@(posedge clk) disable iff (reset_i)
        step |-> (valid_i && acc_op))
        else $error("step flag set without an accumulate op held");

endmodule

// ==== rtl/ex_pkg.sv ====
package ex_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALUOP_W    = 8;
    localparam int ALUSEL_W   = 3;

    // operation subtypes from decode
    localparam logic [ALUOP_W-1:0] EXE_NOP_OP    = 8'b0000_0000;
    localparam logic [ALUOP_W-1:0] EXE_AND_OP    = 8'b0010_0100;
    localparam logic [ALUOP_W-1:0] EXE_OR_OP     = 8'b0010_0101;
    localparam logic [ALUOP_W-1:0] EXE_XOR_OP    = 8'b0010_0110;
    localparam logic [ALUOP_W-1:0] EXE_NOR_OP    = 8'b0010_0111;
    localparam logic [ALUOP_W-1:0] EXE_SLL_OP    = 8'b0111_1100;
    localparam logic [ALUOP_W-1:0] EXE_SRL_OP    = 8'b0000_0010;
    localparam logic [ALUOP_W-1:0] EXE_SRA_OP    = 8'b0000_0011;
    localparam logic [ALUOP_W-1:0] EXE_ADD_OP    = 8'b0010_0000;
    localparam logic [ALUOP_W-1:0] EXE_ADDU_OP   = 8'b0010_0001;
    localparam logic [ALUOP_W-1:0] EXE_SUB_OP    = 8'b0010_0010;
    localparam logic [ALUOP_W-1:0] EXE_SUBU_OP   = 8'b0010_0011;
    localparam logic [ALUOP_W-1:0] EXE_SLT_OP    = 8'b0010_1010;
    localparam logic [ALUOP_W-1:0] EXE_SLTU_OP   = 8'b0010_1011;
    localparam logic [ALUOP_W-1:0] EXE_ADDI_OP   = 8'b0101_0101;
    localparam logic [ALUOP_W-1:0] EXE_ADDIU_OP  = 8'b0101_0110;
    localparam logic [ALUOP_W-1:0] EXE_CLZ_OP    = 8'b1011_0000;
    localparam logic [ALUOP_W-1:0] EXE_CLO_OP    = 8'b1011_0001;
    localparam logic [ALUOP_W-1:0] EXE_MULT_OP   = 8'b0001_1000;
    localparam logic [ALUOP_W-1:0] EXE_MULTU_OP  = 8'b0001_1001;
    localparam logic [ALUOP_W-1:0] EXE_MUL_OP    = 8'b1010_1001;
    localparam logic [ALUOP_W-1:0] EXE_MADD_OP   = 8'b1010_0110;
    localparam logic [ALUOP_W-1:0] EXE_MADDU_OP  = 8'b1010_1000;
    localparam logic [ALUOP_W-1:0] EXE_MSUB_OP   = 8'b1010_1010;
    localparam logic [ALUOP_W-1:0] EXE_MSUBU_OP  = 8'b1010_1011;
    localparam logic [ALUOP_W-1:0] EXE_MFHI_OP   = 8'b0001_0000;
    localparam logic [ALUOP_W-1:0] EXE_MTHI_OP   = 8'b0001_0001;
    localparam logic [ALUOP_W-1:0] EXE_MFLO_OP   = 8'b0001_0010;
    localparam logic [ALUOP_W-1:0] EXE_MTLO_OP   = 8'b0001_0011;

    // result classes, pick the unit whose word gets written back
    localparam logic [ALUSEL_W-1:0] EXE_RES_NOP        = 3'b000;
    localparam logic [ALUSEL_W-1:0] EXE_RES_LOGIC      = 3'b001;
    localparam logic [ALUSEL_W-1:0] EXE_RES_SHIFT      = 3'b010;
    localparam logic [ALUSEL_W-1:0] EXE_RES_MOVE       = 3'b011;
    localparam logic [ALUSEL_W-1:0] EXE_RES_ARITHMETIC = 3'b100;
    localparam logic [ALUSEL_W-1:0] EXE_RES_MUL        = 3'b101;

    typedef struct packed {
        logic [WORD_W-1:0] hi;   // upper word
        logic [WORD_W-1:0] lo;
    } hilo_words_t;

    // HI/LO pair, used as a 64-bit accumulator or as two words
    typedef union packed {
        logic [2*WORD_W-1:0] dword;
        hilo_words_t         w;
    } hilo_t;

endpackage

// ==== rtl/ex_result_sel.sv ====
`timescale 1ns/100ps

module ex_result_sel (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          valid_i,
    input  logic                          stall_i,
    input  logic [ex_pkg::ALUSEL_W-1:0]   alusel_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                          wreg_i,
    input  logic [ex_pkg::WORD_W-1:0]     alu_result_i,
    input  logic                          alu_ov_i,
    input  logic [ex_pkg::WORD_W-1:0]     mul_result_i,
    input  logic [ex_pkg::WORD_W-1:0]     move_result_i,
    output logic                          valid_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                          wreg_o,
    output logic [ex_pkg::WORD_W-1:0]     wdata_o,
    output logic                          ov_o
);

    logic                      accept;
    logic [ex_pkg::WORD_W-1:0] sel_word;

    assign accept = valid_i && !stall_i;

    always_comb begin
        case (alusel_i)
            ex_pkg::EXE_RES_LOGIC,
            ex_pkg::EXE_RES_SHIFT,
            ex_pkg::EXE_RES_ARITHMETIC: sel_word = alu_result_i;
            ex_pkg::EXE_RES_MUL:        sel_word = mul_result_i;
            ex_pkg::EXE_RES_MOVE:       sel_word = move_result_i;
            default:                    sel_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
            ov_o    <= 1'b0;
        end else begin
            valid_o <= accept;
            wreg_o  <= accept && wreg_i && !alu_ov_i;  // overflow cancels the write
            ov_o    <= accept && alu_ov_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wd_o    <= wd_i;
            wdata_o <= sel_word;
        end
    end

    // overflow only ever comes from an arithmetic item, with its write dropped
    assert property (@(posedge clk) disable iff (reset_i)
        ov_o |-> (!wreg_o && ($past(alusel_i) == ex_pkg::EXE_RES_ARITHMETIC)))
        else $error("overflow flagged on a written or non-arithmetic result");

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          valid_i,
    input  logic [ex_pkg::ALUOP_W-1:0]    aluop_i,
    input  logic [ex_pkg::ALUSEL_W-1:0]   alusel_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg1_i,
    input  logic [ex_pkg::WORD_W-1:0]     reg2_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                          wreg_i,
    output logic                          valid_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] wd_o,
    output logic                          wreg_o,
    output logic [ex_pkg::WORD_W-1:0]     wdata_o,
    output logic                          ov_o,
    output logic                          stall_o
);

    logic [ex_pkg::WORD_W-1:0] alu_result;
    logic                      alu_ov;
    logic [ex_pkg::WORD_W-1:0] mul_result;
    logic [ex_pkg::WORD_W-1:0] move_result;  // mfhi / mflo word

    ex_alu u_alu (
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .alu_result_o (alu_result),
        .alu_ov_o     (alu_ov)
    );

    ex_mul_hilo u_mul_hilo (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .aluop_i       (aluop_i),
        .reg1_i        (reg1_i),
        .reg2_i        (reg2_i),
        .mul_result_o  (mul_result),
        .move_result_o (move_result),
        .stall_o       (stall_o)
    );

    ex_result_sel u_result_sel (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .stall_i       (stall_o),
        .alusel_i      (alusel_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .alu_result_i  (alu_result),
        .alu_ov_i      (alu_ov),
        .mul_result_i  (mul_result),
        .move_result_i (move_result),
        .valid_o       (valid_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .ov_o          (ov_o)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vex_stage_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
